/* Bender.yml */
package:
  name: pi1q_to_litedram

sources:
  - files:
      - rtl/pi1_litedram_pkg.sv
      - rtl/pi1_req_buffer.sv
      - rtl/litedram_rdata_capture.sv
      - rtl/litedram_port_fsm.sv
      - rtl/pi1q_to_litedram.sv
  - target: simulation
    files:
      - bench/litedram_port_model.sv
      - bench/tb_pi1q_to_litedram.sv

/* bench/litedram_port_model.sv */
// behavioral LiteDRAM user port with word memory and random stalls
module litedram_port_model
	import pi1_litedram_pkg::*;
(
	input  logic  litedram_clk_i,
	input  logic  cmd_valid_i,
	input  logic  cmd_we_i,
	input  addr_t cmd_addr_i,
	output logic  cmd_ready_o,
	input  logic  wdata_valid_i,
	input  sel_t  wdata_we_i,
	input  data_t wdata_data_i,
	output logic  wdata_ready_o,
	output logic  rdata_valid_o,
	output data_t rdata_data_o,
	input  logic  rdata_ready_i
);

	data_t       mem [256];
	logic [31:0] rng_state;
	logic [7:0]  write_idx;
	data_t       read_word;
	int          read_count;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = '0;
		rng_state     = 32'd20672;
		read_count    = 0;
		cmd_ready_o   = 1'b0;
		wdata_ready_o = 1'b0;
		rdata_valid_o = 1'b0;
		rdata_data_o  = '0;
	end

	// transfers are sampled on the rising edge
	always @(posedge litedram_clk_i) begin
		if (cmd_valid_i && cmd_ready_o) begin
			if (cmd_we_i) begin
				write_idx = cmd_addr_i[7:0];
			end else begin
				read_word = mem[cmd_addr_i[7:0]];
				rng_state = lcg_step(rng_state);
				read_count = 1 + int'(rng_state[17:16] % 2'd3);
			end
		end
		if (wdata_valid_i && wdata_ready_o) begin
			for (int b = 0; b < sel_width_c; b++)
				if (wdata_we_i[b])
					mem[write_idx][8*b +: 8] = wdata_data_i[8*b +: 8];
		end
	end

	// stalls and read responses change on the falling edge
	always @(negedge litedram_clk_i) begin
		rng_state = lcg_step(rng_state);
		cmd_ready_o   <= rng_state[17:16] != 2'd0;
		wdata_ready_o <= rng_state[19:18] != 2'd0;
		// a beat stays valid until the bridge shows ready
		if (rdata_ready_i)
			rdata_valid_o <= 1'b0;
		if (read_count != 0) begin
			read_count = read_count - 1;
			if (read_count == 0) begin
				rdata_valid_o <= 1'b1;
				rdata_data_o  <= read_word;
			end
		end
	end

endmodule

/* bench/tb_pi1q_to_litedram.sv */
// testbench for the pi1 to LiteDRAM bridge
// directed tests against a shadow memory, plus a random run
module tb_pi1q_to_litedram;
	import pi1_litedram_pkg::*;

	logic    clk = 1'b0;
	logic    rst_n;

	// pi1 master side
	pi1_op_e pi1_op;
	addr_t   pi1_addr;
	data_t   pi1_wdata;
	data_t   pi1_rdata;
	sel_t    pi1_sel;
	logic    pi1_rdy;

	// LiteDRAM port side
	logic    cmd_ready;
	logic    cmd_valid;
	logic    cmd_we;
	addr_t   cmd_addr;
	logic    wd_ready;
	logic    wd_valid;
	sel_t    wd_we;
	data_t   wd_data;
	logic    rd_valid;
	data_t   rd_data;
	logic    rd_ready;

	data_t   shadow [256];
	logic [31:0] rng_state = 32'd20672;
	int      errors = 0;
	string   test_name;

	always #20 clk = ~clk;

	pi1q_to_litedram dut (
		.litedram_clk_i(clk),
		.rst_n_i(rst_n),
		.pi1_op_i(pi1_op),
		.pi1_addr_i(pi1_addr),
		.pi1_data_i(pi1_wdata),
		.pi1_data_o(pi1_rdata),
		.pi1_sel_i(pi1_sel),
		.pi1_rdy_o(pi1_rdy),
		.litedram_cmd_ready_i(cmd_ready),
		.litedram_cmd_valid_o(cmd_valid),
		.litedram_cmd_we_o(cmd_we),
		.litedram_cmd_addr_o(cmd_addr),
		.litedram_wdata_ready_i(wd_ready),
		.litedram_wdata_valid_o(wd_valid),
		.litedram_wdata_we_o(wd_we),
		.litedram_wdata_data_o(wd_data),
		.litedram_rdata_valid_i(rd_valid),
		.litedram_rdata_data_i(rd_data),
		.litedram_rdata_ready_o(rd_ready)
	);

	litedram_port_model model (
		.litedram_clk_i(clk),
		.cmd_valid_i(cmd_valid),
		.cmd_we_i(cmd_we),
		.cmd_addr_i(cmd_addr),
		.cmd_ready_o(cmd_ready),
		.wdata_valid_i(wd_valid),
		.wdata_we_i(wd_we),
		.wdata_data_i(wd_data),
		.wdata_ready_o(wd_ready),
		.rdata_valid_o(rd_valid),
		.rdata_data_o(rd_data),
		.rdata_ready_i(rd_ready)
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input sel_t sel);
		data_t r;
		r = old_w;
		for (int b = 0; b < sel_width_c; b++)
			if (sel[b])
				r[8*b +: 8] = new_w[8*b +: 8];
		return r;
	endfunction

	task automatic report_mismatch(input string name, input data_t exp, input data_t act);
		$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		errors++;
	endtask

	// waits on falling edges for pi1_rdy_o, at most 200 cycles
	task automatic wait_ready(input string what);
		int n;
		n = 0;
		while (!pi1_rdy && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (!pi1_rdy) begin
			$display("timeout waiting for pi1_rdy_o %s", what);
			errors++;
		end
	endtask

	// issues one pi1 operation and waits for pi1_rdy_o to return
	task automatic run_op(input pi1_op_e op, input addr_t addr, input data_t data,
			input sel_t sel, output data_t result);
		wait_ready($sformatf("in %s before op %0d at %h", test_name, op, addr));
		pi1_op = op;
		pi1_addr = addr;
		pi1_wdata = data;
		pi1_sel = sel;
		@(negedge clk);
		pi1_op = pi1_noop;
		wait_ready($sformatf("in %s after op %0d at %h", test_name, op, addr));
		result = pi1_rdata;
		// shadow memory holds the expected word for each index
		if (op == pi1_read || op == pi1_swap) begin
			if (result !== shadow[addr[7:0]])
				report_mismatch($sformatf("%s op%0d@%h", test_name, op, addr),
					shadow[addr[7:0]], result);
		end
		if (op == pi1_write || op == pi1_swap)
			shadow[addr[7:0]] = merge_bytes(shadow[addr[7:0]], data, sel);
	endtask

	task automatic reset_state();
		test_name = "reset_state";
		if (pi1_rdy !== 1'b1)
			report_mismatch("reset rdy", 1, pi1_rdy);
		if (cmd_valid !== 1'b0 || wd_valid !== 1'b0)
			report_mismatch("reset valids", 0, {cmd_valid, wd_valid});
		if (rd_ready !== 1'b1)
			report_mismatch("reset rdata ready", 1, rd_ready);
	endtask

	task automatic full_word_writes();
		addr_t addrs [4] = '{30'd3, 30'd17, 30'd200, 30'h3ffff05};
		data_t r;
		test_name = "full_word_writes";
		foreach (addrs[i])
			run_op(pi1_write, addrs[i], 32'h5a000000 ^ (i * 32'h01010101), 4'hf, r);
		foreach (addrs[i])
			run_op(pi1_read, addrs[i], '0, 4'h0, r);
	endtask

	task automatic partial_byte_write();
		data_t r;
		test_name = "partial_byte_write";
		run_op(pi1_write, 30'd40, 32'h11223344, 4'hf, r);
		run_op(pi1_write, 30'd40, 32'haabbccdd, 4'b0101, r);
		run_op(pi1_read, 30'd40, '0, 4'h0, r);
		if (r !== 32'h11bb33dd)
			report_mismatch("partial_write", 32'h11bb33dd, r);
	endtask

	task automatic swap_old_and_new();
		data_t r;
		test_name = "swap_old_and_new";
		run_op(pi1_write, 30'd50, 32'hcafef00d, 4'hf, r);
		run_op(pi1_swap, 30'd50, 32'h12345678, 4'b1100, r);
		if (r !== 32'hcafef00d)
			report_mismatch("swap old", 32'hcafef00d, r);
		run_op(pi1_read, 30'd50, '0, 4'h0, r);
		if (r !== 32'h1234f00d)
			report_mismatch("swap new", 32'h1234f00d, r);
	endtask

	task automatic random_op_run();
		logic [31:0] a, d;
		data_t r;
		test_name = "random_op_run";
		for (int i = 0; i < 30; i++) begin
			a = next_random();
			d = next_random();
			// small index range so addresses repeat
			run_op(pi1_op_e'(2'd1 + a[25:24] % 2'd3), {a[29:8], 4'h0, a[3:0]}, d,
				sel_t'(a[23:20]), r);
		end
	endtask

	initial begin
		for (int i = 0; i < 256; i++)
			shadow[i] = '0;
		rst_n = 1'b0;
		pi1_op = pi1_noop;
		pi1_addr = '0;
		pi1_wdata = '0;
		pi1_sel = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		reset_state();
		full_word_writes();
		partial_byte_write();
		swap_old_and_new();
		random_op_run();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* rtl/litedram_port_fsm.sv */
// state machine driving the LiteDRAM command and write-data channels
// sequences write, read and swap from the buffered pi1 request
module litedram_port_fsm
	import pi1_litedram_pkg::*;
(
	input  logic    litedram_clk_i,
	input  logic    rst_n_i,

	input  logic    req_valid_i,
	input  pi1_op_e req_op_i,
	input  addr_t   req_addr_i,
	input  data_t   req_data_i,
	input  sel_t    req_sel_i,

	input  logic    rdata_held_i,
	input  logic    litedram_rdata_valid_i,

	output logic    read_start_o,
	output logic    op_done_o,

	input  logic    litedram_cmd_ready_i,
	output logic    litedram_cmd_valid_o,
	output logic    litedram_cmd_we_o,
	output addr_t   litedram_cmd_addr_o,

	input  logic    litedram_wdata_ready_i,
	output logic    litedram_wdata_valid_o,
	output sel_t    litedram_wdata_we_o,
	output data_t   litedram_wdata_data_o
);

	port_state_e state;

	// write half of a swap
	addr_t saved_addr;
	sel_t  saved_sel;
	data_t saved_data;

	logic rdata_present;
	logic cmd_fire;
	logic wdata_fire;

	assign rdata_present = litedram_rdata_valid_i || rdata_held_i;
	assign cmd_fire      = litedram_cmd_valid_o && litedram_cmd_ready_i;
	assign wdata_fire    = litedram_wdata_valid_o && litedram_wdata_ready_i;

	// command comes from the request in idle, from the saved address in swap
	always_comb begin
		if (state == st_idle) begin
			litedram_cmd_valid_o = req_valid_i && (req_op_i != pi1_noop);
			litedram_cmd_we_o    = (req_op_i == pi1_write);
			litedram_cmd_addr_o  = req_addr_i;
		end else begin
			litedram_cmd_valid_o = (state == st_swap) && rdata_present;
			litedram_cmd_we_o    = (state == st_swap);
			litedram_cmd_addr_o  = saved_addr;
		end
	end

	assign litedram_wdata_valid_o = (state == st_write);

	// read and swap both start a capture when their read command goes out
	assign read_start_o = (state == st_idle) && cmd_fire &&
		((req_op_i == pi1_read) || (req_op_i == pi1_swap));

	assign op_done_o = ((state == st_write) && wdata_fire) ||
		((state == st_read) && rdata_present);

	always_ff @(posedge litedram_clk_i) begin
		if (!rst_n_i) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (cmd_fire) begin
						case (req_op_i)
							pi1_write: state <= st_write;
							pi1_read:  state <= st_read;
							pi1_swap:  state <= st_swap;
							default:   state <= st_idle;
						endcase
					end
				end
				st_write: begin
					if (wdata_fire)
						state <= st_idle;
				end
				st_read: begin
					if (rdata_present)
						state <= st_idle;
				end
				st_swap: begin
					// cmd_fire here implies the old word has arrived
					if (cmd_fire)
						state <= st_write;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// write-data payload and swap save registers
	always_ff @(posedge litedram_clk_i) begin
		if (state == st_idle && cmd_fire) begin
			if (req_op_i == pi1_write) begin
				litedram_wdata_we_o   <= req_sel_i;
				litedram_wdata_data_o <= req_data_i;
			end
			if (req_op_i == pi1_swap) begin
				saved_addr <= req_addr_i;
				saved_sel  <= req_sel_i;
				saved_data <= req_data_i;
			end
		end else if (state == st_swap && cmd_fire) begin
			litedram_wdata_we_o   <= saved_sel;
			litedram_wdata_data_o <= saved_data;
		end
	end

endmodule

/* rtl/litedram_rdata_capture.sv */
// capture of the first LiteDRAM read-data beat after each read command
module litedram_rdata_capture
	import pi1_litedram_pkg::*;
(
	input  logic  litedram_clk_i,
	input  logic  rst_n_i,

	input  logic  read_start_i,

	input  logic  litedram_rdata_valid_i,
	input  data_t litedram_rdata_data_i,
	output logic  litedram_rdata_ready_o,

	output logic  rdata_held_o,
	output data_t rdata_word_o
);

	logic take_beat;

	// read data is always accepted
	assign litedram_rdata_ready_o = 1'b1;

	// only the first beat after a start counts
	assign take_beat = litedram_rdata_valid_i && !rdata_held_o;

	always_ff @(posedge litedram_clk_i) begin
		if (!rst_n_i) begin
			rdata_held_o <= 1'b0;
			rdata_word_o <= '0;
		end else if (read_start_i) begin
			// a new read clears the flag and leaves the old word visible
			rdata_held_o <= 1'b0;
		end else if (take_beat) begin
			rdata_held_o <= 1'b1;
			rdata_word_o <= litedram_rdata_data_i;
		end
	end

endmodule

/* rtl/pi1_litedram_pkg.sv */
// widths, vector typedefs and enums shared by the pi1 to LiteDRAM bridge
package pi1_litedram_pkg;

	// fixed bus geometry
	localparam int data_width_c = 32;
	localparam int sel_width_c  = data_width_c / 8;
	localparam int addr_width_c = 30;

	typedef logic [data_width_c-1:0] data_t;
	typedef logic [sel_width_c-1:0]  sel_t;
	typedef logic [addr_width_c-1:0] addr_t;

	// pi1 operation codes as seen on pi1_op_i
	typedef enum logic [1:0] {
		pi1_noop  = 2'd0,
		pi1_write = 2'd1,
		pi1_read  = 2'd2,
		pi1_swap  = 2'd3
	} pi1_op_e;

	// st_swap waits for read data before its write half
	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_write = 2'd1,
		st_read  = 2'd2,
		st_swap  = 2'd3
	} port_state_e;

endpackage

/* rtl/pi1_req_buffer.sv */
// one-entry request buffer for the pi1 master
// holds the request until the port state machine reports completion
module pi1_req_buffer
	import pi1_litedram_pkg::*;
(
	input  logic    litedram_clk_i,
	input  logic    rst_n_i,

	input  pi1_op_e pi1_op_i,
	input  addr_t   pi1_addr_i,
	input  data_t   pi1_data_i,
	input  sel_t    pi1_sel_i,
	output logic    pi1_rdy_o,

	input  logic    op_done_i,
	output logic    req_valid_o,
	output pi1_op_e req_op_o,
	output addr_t   req_addr_o,
	output data_t   req_data_o,
	output sel_t    req_sel_o
);

	logic full;
	logic accept;

	// master is ready whenever the slot is free
	assign pi1_rdy_o   = !full;
	assign req_valid_o = full;
	assign accept      = !full && (pi1_op_i != pi1_noop);

	always_ff @(posedge litedram_clk_i) begin
		if (!rst_n_i) begin
			full     <= 1'b0;
			req_op_o <= pi1_noop;
		end else if (accept) begin
			full     <= 1'b1;
			req_op_o <= pi1_op_i;
		end else if (op_done_i) begin
			full <= 1'b0;
		end
	end

	// payload only changes on acceptance
	always_ff @(posedge litedram_clk_i) begin
		if (accept) begin
			req_addr_o <= pi1_addr_i;
			req_data_o <= pi1_data_i;
			req_sel_o  <= pi1_sel_i;
		end
	end

endmodule

/* rtl/pi1q_to_litedram.sv */
// pi1 to LiteDRAM native port bridge
// request buffer and read capture feeding the port state machine
module pi1q_to_litedram
	import pi1_litedram_pkg::*;
(
	input  logic    litedram_clk_i,
	input  logic    rst_n_i,

	// pi1 master side
	input  pi1_op_e pi1_op_i,
	input  addr_t   pi1_addr_i,
	input  data_t   pi1_data_i,
	output data_t   pi1_data_o,
	input  sel_t    pi1_sel_i,
	output logic    pi1_rdy_o,

	// LiteDRAM user port
	input  logic    litedram_cmd_ready_i,
	output logic    litedram_cmd_valid_o,
	output logic    litedram_cmd_we_o,
	output addr_t   litedram_cmd_addr_o,
	input  logic    litedram_wdata_ready_i,
	output logic    litedram_wdata_valid_o,
	output sel_t    litedram_wdata_we_o,
	output data_t   litedram_wdata_data_o,
	input  logic    litedram_rdata_valid_i,
	input  data_t   litedram_rdata_data_i,
	output logic    litedram_rdata_ready_o
);

	logic    req_valid;
	pi1_op_e req_op;
	addr_t   req_addr;
	data_t   req_data;
	sel_t    req_sel;
	logic    op_done;
	logic    read_start;
	logic    rdata_held;

	pi1_req_buffer u_req_buffer (
		.litedram_clk_i (litedram_clk_i),
		.rst_n_i        (rst_n_i),
		.pi1_op_i       (pi1_op_i),
		.pi1_addr_i     (pi1_addr_i),
		.pi1_data_i     (pi1_data_i),
		.pi1_sel_i      (pi1_sel_i),
		.pi1_rdy_o      (pi1_rdy_o),
		.op_done_i      (op_done),
		.req_valid_o    (req_valid),
		.req_op_o       (req_op),
		.req_addr_o     (req_addr),
		.req_data_o     (req_data),
		.req_sel_o      (req_sel)
	);

	// held word doubles as the pi1 read data
	litedram_rdata_capture u_rdata_capture (
		.litedram_clk_i         (litedram_clk_i),
		.rst_n_i                (rst_n_i),
		.read_start_i           (read_start),
		.litedram_rdata_valid_i (litedram_rdata_valid_i),
		.litedram_rdata_data_i  (litedram_rdata_data_i),
		.litedram_rdata_ready_o (litedram_rdata_ready_o),
		.rdata_held_o           (rdata_held),
		.rdata_word_o           (pi1_data_o)
	);

	litedram_port_fsm u_port_fsm (
		.litedram_clk_i         (litedram_clk_i),
		.rst_n_i                (rst_n_i),
		.req_valid_i            (req_valid),
		.req_op_i               (req_op),
		.req_addr_i             (req_addr),
		.req_data_i             (req_data),
		.req_sel_i              (req_sel),
		.rdata_held_i           (rdata_held),
		.litedram_rdata_valid_i (litedram_rdata_valid_i),
		.read_start_o           (read_start),
		.op_done_o              (op_done),
		.litedram_cmd_ready_i   (litedram_cmd_ready_i),
		.litedram_cmd_valid_o   (litedram_cmd_valid_o),
		.litedram_cmd_we_o      (litedram_cmd_we_o),
		.litedram_cmd_addr_o    (litedram_cmd_addr_o),
		.litedram_wdata_ready_i (litedram_wdata_ready_i),
		.litedram_wdata_valid_o (litedram_wdata_valid_o),
		.litedram_wdata_we_o    (litedram_wdata_we_o),
		.litedram_wdata_data_o  (litedram_wdata_data_o)
	);

endmodule

/* sim.f */
rtl/pi1_litedram_pkg.sv
rtl/pi1_req_buffer.sv
rtl/litedram_rdata_capture.sv
rtl/litedram_port_fsm.sv
rtl/pi1q_to_litedram.sv
bench/litedram_port_model.sv
bench/tb_pi1q_to_litedram.sv
